/* apu_pulse_pkg.sv */
`default_nettype none

package apu_pulse_pkg;

	// Widths and counts
	localparam int NUM_CH  = 2;
	localparam int DATA_W  = 8;
	localparam int ADDR_W  = 5;
	localparam int VOL_W   = 4;
	localparam int MIX_W   = 5;
	localparam int TIMER_W = 11;
	localparam int LEN_W   = 8;

	// Index into the note-length table
	localparam int LEN_IDX_W = 5;

	// Register map, channel in addr[4:2] and register in addr[1:0]
	localparam int REG_PER_CH = 4;
	localparam logic [1:0] REG_CTRL  = 2'd0;
	localparam logic [1:0] REG_TIMER = 2'd2;
	localparam logic [1:0] REG_LEN   = 2'd3;
	localparam logic [ADDR_W-1:0] ADDR_STATUS = 5'h15;

	// Frame timing in sys_clk cycles
	localparam int APU_DIV    = 2;
	// Far shorter than real hardware to keep runs quick
	localparam int QFRAME_DIV = 256;

	localparam int APU_CNT_W    = $clog2(APU_DIV);
	localparam int QFRAME_CNT_W = $clog2(QFRAME_DIV);

endpackage

`default_nettype wire

/* apu_length_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_length_rom
	import apu_pulse_pkg::*;
(
	input  logic                 sys_clk,
	input  logic [LEN_IDX_W-1:0] length_idx,
	output logic [LEN_W-1:0]     length_val
);

	// Standard note-length table, registered output
	always_ff @(posedge sys_clk) begin
		case (length_idx)
			5'd0:  length_val <= 8'd10;
			5'd1:  length_val <= 8'd254;
			5'd2:  length_val <= 8'd20;
			5'd3:  length_val <= 8'd2;
			5'd4:  length_val <= 8'd40;
			5'd5:  length_val <= 8'd4;
			5'd6:  length_val <= 8'd80;
			5'd7:  length_val <= 8'd6;
			5'd8:  length_val <= 8'd160;
			5'd9:  length_val <= 8'd8;
			5'd10: length_val <= 8'd60;
			5'd11: length_val <= 8'd10;
			5'd12: length_val <= 8'd14;
			5'd13: length_val <= 8'd12;
			5'd14: length_val <= 8'd26;
			5'd15: length_val <= 8'd14;
			5'd16: length_val <= 8'd12;
			5'd17: length_val <= 8'd16;
			5'd18: length_val <= 8'd24;
			5'd19: length_val <= 8'd18;
			5'd20: length_val <= 8'd48;
			5'd21: length_val <= 8'd20;
			5'd22: length_val <= 8'd96;
			5'd23: length_val <= 8'd22;
			5'd24: length_val <= 8'd192;
			5'd25: length_val <= 8'd24;
			5'd26: length_val <= 8'd72;
			5'd27: length_val <= 8'd26;
			5'd28: length_val <= 8'd16;
			5'd29: length_val <= 8'd28;
			5'd30: length_val <= 8'd32;
			default: length_val <= 8'd30;
		endcase
	end

endmodule

`default_nettype wire

/* apu_frame_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_frame_seq
	import apu_pulse_pkg::*;
(
	input  logic sys_clk,
	input  logic sys_rst_n,
	output logic apu_tick,
	output logic qframe,
	output logic hframe
);

	logic [APU_CNT_W-1:0]    apu_cnt;
	logic [QFRAME_CNT_W-1:0] qf_cnt;
	logic                    half;

	// APU-rate divider
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			apu_cnt  <= '0;
			apu_tick <= 1'b0;
		end else if (apu_cnt == APU_CNT_W'(APU_DIV - 1)) begin
			apu_cnt  <= '0;
			apu_tick <= 1'b1;
		end else begin
			apu_cnt  <= apu_cnt + 1'b1;
			apu_tick <= 1'b0;
		end
	end

	// Quarter-frame counter, every other one is also a half frame
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			qf_cnt <= '0;
			half   <= 1'b0;
			qframe <= 1'b0;
			hframe <= 1'b0;
		end else if (qf_cnt == QFRAME_CNT_W'(QFRAME_DIV - 1)) begin
			qf_cnt <= '0;
			half   <= ~half;
			qframe <= 1'b1;
			hframe <= half;
		end else begin
			qf_cnt <= qf_cnt + 1'b1;
			qframe <= 1'b0;
			hframe <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* apu_reg_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_reg_decode
	import apu_pulse_pkg::*;
(
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  logic [ADDR_W-1:0] bus_addr,
	input  logic [DATA_W-1:0] bus_wdata,
	input  logic              bus_we,
	input  logic              bus_re,
	input  logic [NUM_CH-1:0] ch_act,
	output logic [NUM_CH-1:0] ch_sel,
	output logic [NUM_CH-1:0] ch_en,
	output logic [DATA_W-1:0] bus_rdata
);

	logic status_hit;

	assign status_hit = bus_addr == ADDR_STATUS;

	// Channel number sits above the two register bits
	always_comb begin
		for (int i = 0; i < NUM_CH; i++)
			ch_sel[i] = bus_addr[ADDR_W-1:2] == (ADDR_W-2)'(i);
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			ch_en <= '0;
		else if (bus_we && status_hit)
			ch_en <= bus_wdata[NUM_CH-1:0];
	end

	// Read data holds until the next read strobe
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			bus_rdata <= '0;
		else if (bus_re)
			bus_rdata <= status_hit ? DATA_W'(ch_act) : '0;
	end

endmodule

`default_nettype wire

/* apu_pulse.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_pulse
	import apu_pulse_pkg::*;
(
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  logic              apu_tick,
	input  logic              qframe,
	input  logic              hframe,
	input  logic              sel,
	input  logic              en,
	input  logic [1:0]        reg_addr,
	input  logic [DATA_W-1:0] reg_wdata,
	input  logic              reg_we,
	output logic              act,
	output logic [VOL_W-1:0]  out
);

	logic we;
	logic len_we;
	logic [DATA_W-1:0] regs [REG_PER_CH];

	assign we     = sel & reg_we;
	assign len_we = we && reg_addr == REG_LEN;

	// Register 1 holds the sweep setup, kept but not acted on
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			for (int i = 0; i < REG_PER_CH; i++)
				regs[i] <= '0;
		end else if (!en) begin
			for (int i = 0; i < REG_PER_CH; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[reg_addr] <= reg_wdata;
		end
	end

	logic [1:0]           duty;
	logic                 halt;
	logic                 const_vol;
	logic [VOL_W-1:0]     vol;
	logic [TIMER_W-1:0]   period;
	logic [LEN_IDX_W-1:0] length_idx;

	assign duty       = regs[REG_CTRL][7:6];
	assign halt       = regs[REG_CTRL][5];
	assign const_vol  = regs[REG_CTRL][4];
	// Volume doubles as the envelope period, halt as envelope loop
	assign vol        = regs[REG_CTRL][3:0];
	assign period     = {regs[REG_LEN][2:0], regs[REG_TIMER]};
	assign length_idx = regs[REG_LEN][7:3];

	// Period timer and duty sequencer
	logic [TIMER_W-1:0] timer_cnt;
	logic [2:0]         seq_step;
	logic               gate_timer;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			timer_cnt  <= '0;
			seq_step   <= '0;
			gate_timer <= 1'b0;
		end else if (!en) begin
			timer_cnt  <= '0;
			seq_step   <= '0;
			gate_timer <= 1'b0;
		end else if (apu_tick) begin
			if (timer_cnt == '0) begin
				timer_cnt  <= period;
				seq_step   <= seq_step - 3'd1;
				// Periods below 8 are ultrasonic, mute them
				gate_timer <= period[TIMER_W-1:3] != '0;
			end else begin
				timer_cnt <= timer_cnt - 1'b1;
			end
		end
	end

	logic gate_seq;

	always_comb begin
		case (duty)
			2'd0:    gate_seq = seq_step == 3'b111;
			2'd1:    gate_seq = seq_step[2:1] == 2'b11;
			2'd2:    gate_seq = seq_step[2];
			default: gate_seq = seq_step[2:1] != 2'b11;
		endcase
	end

	// Envelope
	logic             env_start;
	logic [VOL_W-1:0] env_div;
	logic [VOL_W-1:0] env_cnt;
	logic [VOL_W-1:0] env_out;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			env_start <= 1'b0;
			env_div   <= '0;
			env_cnt   <= '0;
		end else if (!en) begin
			env_start <= 1'b0;
			env_div   <= '0;
			env_cnt   <= '0;
		end else begin
			if (len_we)
				env_start <= 1'b1;
			else if (qframe)
				env_start <= 1'b0;

			if (qframe) begin
				if (env_start) begin
					env_div <= vol;
					env_cnt <= '1;
				end else if (env_div == '0) begin
					env_div <= vol;
					if (halt || env_cnt != '0)
						env_cnt <= env_cnt - 1'b1;
				end else begin
					env_div <= env_div - 1'b1;
				end
			end
		end
	end

	assign env_out = const_vol ? vol : env_cnt;

	// Length counter
	logic             lc_req;
	logic             lc_pending;
	logic             gate_lc;
	logic [LEN_W-1:0] lc_cnt;
	logic [LEN_W-1:0] length_val;

	apu_length_rom u_length_rom (
		.sys_clk    (sys_clk),
		.length_idx (length_idx),
		.length_val (length_val)
	);

	// lc_req waits a cycle so the table output matches the new index
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			lc_req     <= 1'b0;
			lc_pending <= 1'b0;
			lc_cnt     <= '0;
			gate_lc    <= 1'b0;
		end else begin
			lc_req <= len_we & en;
			if (hframe)
				gate_lc <= en && lc_cnt != '0;

			if (!en) begin
				lc_pending <= 1'b0;
				lc_cnt     <= '0;
			end else if (hframe && lc_pending) begin
				lc_cnt     <= length_val;
				lc_pending <= lc_req;
			end else begin
				if (lc_req)
					lc_pending <= 1'b1;
				if (hframe && !halt && lc_cnt != '0)
					lc_cnt <= lc_cnt - 1'b1;
			end
		end
	end

	assign act = gate_lc;
	assign out = (en && gate_lc && gate_timer && gate_seq) ? env_out : '0;

endmodule

`default_nettype wire

/* apu_pulse_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_pulse_mixer
	import apu_pulse_pkg::*;
(
	input  logic                         sys_clk,
	input  logic                         sys_rst_n,
	input  logic [NUM_CH-1:0][VOL_W-1:0] ch_out,
	output logic [MIX_W-1:0]             audio_out
);

	logic [MIX_W-1:0] sum;

	// Plain linear sum
	always_comb begin
		sum = '0;
		for (int i = 0; i < NUM_CH; i++)
			sum = sum + MIX_W'(ch_out[i]);
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			audio_out <= '0;
		else
			audio_out <= sum;
	end

endmodule

`default_nettype wire

/* apu_pulse_top.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_pulse_top
	import apu_pulse_pkg::*;
(
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  logic [ADDR_W-1:0] bus_addr,
	input  logic [DATA_W-1:0] bus_wdata,
	input  logic              bus_we,
	input  logic              bus_re,
	output logic [DATA_W-1:0] bus_rdata,
	output logic [MIX_W-1:0]  audio_out
);

	logic apu_tick;
	logic qframe;
	logic hframe;

	logic [NUM_CH-1:0]            ch_sel;
	logic [NUM_CH-1:0]            ch_en;
	logic [NUM_CH-1:0]            ch_act;
	logic [NUM_CH-1:0][VOL_W-1:0] ch_out;

	apu_frame_seq u_frame_seq (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.apu_tick  (apu_tick),
		.qframe    (qframe),
		.hframe    (hframe)
	);

	apu_reg_decode u_reg_decode (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_we    (bus_we),
		.bus_re    (bus_re),
		.ch_act    (ch_act),
		.ch_sel    (ch_sel),
		.ch_en     (ch_en),
		.bus_rdata (bus_rdata)
	);

	// Register address and data are shared, ch_sel picks the channel
	generate
		for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
			apu_pulse u_pulse (
				.sys_clk   (sys_clk),
				.sys_rst_n (sys_rst_n),
				.apu_tick  (apu_tick),
				.qframe    (qframe),
				.hframe    (hframe),
				.sel       (ch_sel[i]),
				.en        (ch_en[i]),
				.reg_addr  (bus_addr[1:0]),
				.reg_wdata (bus_wdata),
				.reg_we    (bus_we),
				.act       (ch_act[i]),
				.out       (ch_out[i])
			);
		end
	endgenerate

	apu_pulse_mixer u_mixer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.ch_out    (ch_out),
		.audio_out (audio_out)
	);

endmodule

`default_nettype wire

/* tb_apu_pulse.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_apu_pulse
	import apu_pulse_pkg::*;
();

	localparam int HFRAME_CYC  = 2 * QFRAME_DIV;
	localparam int ACT_TIMEOUT = 3 * HFRAME_CYC;
	// Index 5 of the note-length table holds 4
	localparam logic [4:0] LEN_IDX = 5'd5;
	localparam int LEN_HF = 4;

	logic              sys_clk;
	logic              sys_rst_n;
	logic [ADDR_W-1:0] bus_addr;
	logic [DATA_W-1:0] bus_wdata;
	logic              bus_we;
	logic              bus_re;
	logic [DATA_W-1:0] bus_rdata;
	logic [MIX_W-1:0]  audio_out;

	integer seed = 32'hd736_6093;
	int errors = 0;
	int checks = 0;
	int cyc = 0;

	apu_pulse_top uut (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_we    (bus_we),
		.bus_re    (bus_re),
		.bus_rdata (bus_rdata),
		.audio_out (audio_out)
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	always @(posedge sys_clk)
		cyc <= cyc + 1;

	task automatic check(input string name, input int expected, input int actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		@(posedge sys_clk);
		bus_addr  <= addr;
		bus_wdata <= data;
		bus_we    <= 1'b1;
		@(posedge sys_clk);
		bus_we <= 1'b0;
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		@(posedge sys_clk);
		bus_addr <= addr;
		bus_re   <= 1'b1;
		@(posedge sys_clk);
		bus_re <= 1'b0;
		@(negedge sys_clk);
		data = bus_rdata;
	endtask

	// Poll the status register until the masked bits match
	task automatic wait_status(input string name, input logic [7:0] mask,
			input logic [7:0] value, input int timeout);
		int start;
		logic [7:0] data;
		start = cyc;
		bus_read(ADDR_STATUS, data);
		while ((data & mask) != value && cyc - start < timeout)
			bus_read(ADDR_STATUS, data);
		if ((data & mask) != value) begin
			errors++;
			$display("%s: status bits %h never reached %h within %0d cycles",
				name, mask, value, timeout);
		end
	endtask

	task automatic measure_output(input int cycles, input logic [MIX_W-1:0] level,
			output int hits, output int peak, output int others);
		hits   = 0;
		peak   = 0;
		others = 0;
		repeat (cycles) begin
			@(negedge sys_clk);
			if (audio_out == level)
				hits++;
			else if (audio_out != '0)
				others++;
			if (int'(audio_out) > peak)
				peak = int'(audio_out);
		end
	endtask

	// Disable everything, let act drop, then enable the given channels
	task automatic restart(input logic [NUM_CH-1:0] mask);
		bus_write(ADDR_STATUS, 8'h00);
		wait_status("restart", 8'hff, 8'h00, ACT_TIMEOUT);
		bus_write(ADDR_STATUS, DATA_W'(mask));
	endtask

	task automatic setup_channel(input int ch, input logic [7:0] ctrl,
			input logic [TIMER_W-1:0] period, input logic [4:0] len_idx);
		logic [ADDR_W-1:0] base;
		base = ADDR_W'(ch * REG_PER_CH);
		bus_write(base, ctrl);
		bus_write(base + 2, period[7:0]);
		bus_write(base + 3, {len_idx, period[10:8]});
	endtask

	task automatic test_reset();
		logic [7:0] data;
		int e0;
		e0 = errors;
		@(negedge sys_clk);
		check("reset audio", 0, int'(audio_out));
		bus_read(ADDR_STATUS, data);
		check("reset status", 0, int'(data));
		$display("test reset done, %0d errors", errors - e0);
	endtask

	task automatic test_duty();
		int r, vol, t, k, hits, peak, others, e0;
		e0 = errors;
		for (int d = 0; d < 4; d++) begin
			r   = $random(seed);
			vol = 1 + r[7:0] % 15;
			t   = 8 + r[12:8];
			k   = (d == 0) ? 1 : (d == 1) ? 2 : (d == 2) ? 4 : 6;
			restart(1);
			setup_channel(0, {d[1:0], 1'b1, 1'b1, vol[3:0]}, t, 5'd1);
			wait_status("duty", 8'h01, 8'h01, ACT_TIMEOUT);
			// One full 8-step waveform
			measure_output(16 * (t + 1), vol, hits, peak, others);
			check($sformatf("duty %0d level count", d), 2 * (t + 1) * k, hits);
			check($sformatf("duty %0d stray levels", d), 0, others);
		end
		$display("test duty done, %0d errors", errors - e0);
	endtask

	task automatic test_timer_mute();
		int r, t, hits, peak, others, e0;
		e0 = errors;
		r = $random(seed);
		t = r[2:0];
		restart(1);
		setup_channel(0, {2'b10, 1'b1, 1'b1, 4'hf}, t, 5'd1);
		wait_status("timer mute", 8'h01, 8'h01, ACT_TIMEOUT);
		measure_output(16 * 8 * 2, 0, hits, peak, others);
		check("timer mute peak", 0, peak);
		$display("test timer_mute done, %0d errors", errors - e0);
	endtask

	task automatic test_length();
		int r, vol, t, rise, hf, e0;
		logic [7:0] data;
		e0 = errors;
		r   = $random(seed);
		vol = 1 + r[7:0] % 15;
		t   = 8 + r[12:8];
		restart(1);
		setup_channel(0, {2'b10, 1'b0, 1'b1, vol[3:0]}, t, LEN_IDX);
		wait_status("length rise", 8'h01, 8'h01, ACT_TIMEOUT);
		rise = cyc;
		wait_status("length fall", 8'h01, 8'h00, (LEN_HF + 4) * HFRAME_CYC);
		hf = (cyc - rise + HFRAME_CYC / 2) / HFRAME_CYC;
		if (hf >= LEN_HF - 2 && hf <= LEN_HF + 2)
			hf = LEN_HF;
		check("length half frames", LEN_HF, hf);

		// Halt freezes the counter
		bus_write(0, {2'b10, 1'b1, 1'b1, vol[3:0]});
		bus_write(3, {LEN_IDX, 3'b000});
		wait_status("length halt rise", 8'h01, 8'h01, ACT_TIMEOUT);
		repeat ((LEN_HF + 3) * HFRAME_CYC) @(posedge sys_clk);
		bus_read(ADDR_STATUS, data);
		check("length halt act", 1, int'(data[0]));
		$display("test length done, %0d errors", errors - e0);
	endtask

	task automatic test_envelope();
		int r, p, t, start, hits, peak, others, e0;
		e0 = errors;
		r = $random(seed);
		p = r[1:0];
		t = 8 + r[6:4];
		restart(1);
		setup_channel(0, {2'b10, 1'b1, 1'b1, 4'h0}, t, 5'd1);
		wait_status("envelope", 8'h01, 8'h01, ACT_TIMEOUT);
		bus_write(0, {2'b10, 1'b0, 1'b0, p[3:0]});
		bus_write(3, {5'd1, 3'b000});
		// Spans the first quarter frame after the restart
		measure_output(3 * QFRAME_DIV, 15, hits, peak, others);
		check("envelope start peak", 15, peak);
		start = cyc;
		peak  = 1;
		while (peak != 0 && cyc - start < (16 * (p + 1) + 4) * QFRAME_DIV)
			measure_output(16 * (t + 1), 0, hits, peak, others);
		if (peak != 0) begin
			errors++;
			$display("envelope: level did not decay to zero before the timeout");
		end
		measure_output(4 * QFRAME_DIV, 0, hits, peak, others);
		check("envelope hold", 0, peak);
		$display("test envelope done, %0d errors", errors - e0);
	endtask

	task automatic test_mix();
		int r, v0, v1, t, hits, peak, others, e0;
		logic [7:0] data;
		e0 = errors;
		r  = $random(seed);
		v0 = 1 + r[7:0] % 15;
		v1 = 1 + r[15:8] % 15;
		t  = 8 + r[20:16];
		restart(3);
		bus_write(0, {2'b10, 1'b1, 1'b1, v0[3:0]});
		bus_write(4, {2'b10, 1'b1, 1'b1, v1[3:0]});
		// Period writes back to back keep the two phases close
		bus_write(2, t[7:0]);
		bus_write(6, t[7:0]);
		bus_write(3, {5'd1, 3'b000});
		bus_write(7, {5'd1, 3'b000});
		wait_status("mix", 8'h03, 8'h03, ACT_TIMEOUT);
		measure_output(16 * (t + 1), v0 + v1, hits, peak, others);
		check("mix peak", v0 + v1, peak);

		bus_write(ADDR_STATUS, 8'h01);
		// Mixer adds one cycle
		@(posedge sys_clk);
		measure_output(16 * (t + 1), v0, hits, peak, others);
		check("mix ch0 only peak", v0, peak);
		wait_status("mix disable", 8'h02, 8'h00, HFRAME_CYC + 16);
		bus_read(ADDR_STATUS, data);
		check("mix status", 1, int'(data));
		$display("test mix done, %0d errors", errors - e0);
	endtask

	initial begin
		sys_rst_n = 1'b0;
		bus_addr  = '0;
		bus_wdata = '0;
		bus_we    = 1'b0;
		bus_re    = 1'b0;
		repeat (10) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(posedge sys_clk);

		test_reset();
		test_duty();
		test_timer_mute();
		test_length();
		test_envelope();
		test_mix();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* apu_pulse.f */
apu_pulse_pkg.sv
apu_length_rom.sv
apu_frame_seq.sv
apu_reg_decode.sv
apu_pulse.sv
apu_pulse_mixer.sv
apu_pulse_top.sv
tb_apu_pulse.sv

/* Makefile */
SRCS := $(shell cat apu_pulse.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_apu_pulse: apu_pulse.f $(SRCS)
	verilator --binary --timing -Wno-fatal -j 0 -f apu_pulse.f --top-module tb_apu_pulse -Mdir obj_dir

run: obj_dir/Vtb_apu_pulse
	./obj_dir/Vtb_apu_pulse | tee sim.log
	grep -qx "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
